// File: rtl/stack_pkg.sv
package stack_pkg;

	// ------------------------------------------------------------
	// Default sizes, picked up by the top level and the testbench
	// ------------------------------------------------------------

	// Number of stack entries
	localparam int STACK_DEPTH_DEF = 16;

	localparam int DATA_W_DEF      = 16;    // Payload width in bits

	// ------------------------------------------------------------
	// Error flag behaviour
	// ------------------------------------------------------------

	// ERR_STICKY    -> flag holds from the first bad request until reset
	// ERR_PER_CYCLE -> flag shows only the previous cycle's request
	typedef enum logic
	{
		ERR_STICKY    = 1'b0,
		ERR_PER_CYCLE = 1'b1
	} err_mode_e;

endpackage

// File: rtl/stack_ctl.sv
`timescale 1ns/1ps

module stack_ctl #(
	parameter int                   DEPTH    = stack_pkg::STACK_DEPTH_DEF,
	parameter stack_pkg::err_mode_e ERR_MODE = stack_pkg::ERR_STICKY,
	// Address width, at least one bit even for a single entry
	localparam int                  ADDR_W   = ($clog2(DEPTH) < 1) ? 1 : $clog2(DEPTH)
) (
	input  logic              clk,
	input  logic              rst_n,        // Async, active low
	input  logic              push_req_n,   // Push request, active low
	input  logic              pop_req_n,    // Pop request, active low
	output logic              we_n,         // RAM write enable, active low
	output logic              rd_en,        // Pop accepted this cycle
	output logic [ADDR_W-1:0] wr_addr,      // Next free slot
	output logic [ADDR_W-1:0] rd_addr,      // Current top of stack
	output logic              empty,
	output logic              full,
	output logic              error
);

	import stack_pkg::*;

	// Pointer must reach DEPTH itself, one more than the top address
	localparam int              SP_W    = $clog2(DEPTH + 1);
	localparam logic [SP_W-1:0] SP_FULL = SP_W'(DEPTH);

	logic [SP_W-1:0] sp;          // Number of stored items
	logic [SP_W-1:0] sp_next;
	logic [SP_W-1:0] sp_dec;      // sp minus one, top entry
	logic            push_ok;     // Push accepted
	logic            pop_ok;      // Pop accepted
	logic            err_cond;    // Bad request this cycle

	// ------------------------------------------------------------
	// Request acceptance
	// ------------------------------------------------------------

	// Push wins over pop when both are low
	assign push_ok = !push_req_n && !full;
	assign pop_ok  = !pop_req_n && push_req_n && !empty;

	assign we_n  = !push_ok;      // Low while a push is taken
	assign rd_en = pop_ok;

	// ------------------------------------------------------------
	// Address generation
	// ------------------------------------------------------------

	// Write goes to the slot just above the top
	assign sp_dec  = sp - SP_W'(1);
	assign wr_addr = sp[ADDR_W-1:0];
	assign rd_addr = sp_dec[ADDR_W-1:0];    // Wraps when empty, rd_en is low then

	// ------------------------------------------------------------
	// Stack pointer and flags
	// ------------------------------------------------------------

	always_comb
	begin
		sp_next = sp;                       // Hold by default
		if (push_ok)
		begin
			sp_next = sp + SP_W'(1);
		end
		else if (pop_ok)
		begin
			sp_next = sp_dec;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sp    <= '0;
			empty <= 1'b1;                  // Nothing stored after reset
			full  <= 1'b0;
		end
		else
		begin
			sp    <= sp_next;
			// Flags follow the new count, so they line up with sp
			empty <= (sp_next == '0);
			full  <= (sp_next == SP_FULL);
		end
	end

	// ------------------------------------------------------------
	// Error detection
	// ------------------------------------------------------------

	// Judged against the registered flags, same as acceptance
	// A pop with a push alongside is never an error
	assign err_cond = (!push_req_n && full) ||
	                  (!pop_req_n && push_req_n && empty);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			error <= 1'b0;
		end
		else if (ERR_MODE == ERR_STICKY)
		begin
			if (err_cond)
			begin
				error <= 1'b1;              // Latches until reset
			end
		end
		else
		begin
			error <= err_cond;              // Last cycle only
		end
	end

endmodule

// File: rtl/stack_ram.sv
`timescale 1ns/1ps

module stack_ram #(
	parameter int  DEPTH     = stack_pkg::STACK_DEPTH_DEF,
	parameter type payload_t = logic [stack_pkg::DATA_W_DEF-1:0],
	localparam int ADDR_W    = ($clog2(DEPTH) < 1) ? 1 : $clog2(DEPTH)
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              we_n,         // Active low
	input  logic [ADDR_W-1:0] wr_addr,
	input  payload_t          wr_data,
	input  logic              rd_en,
	input  logic [ADDR_W-1:0] rd_addr,
	output payload_t          rd_data,      // Valid the cycle after rd_en
	output logic              rd_valid
);

	payload_t mem [DEPTH];        // Storage array

	// ------------------------------------------------------------
	// Write and read ports, both on the rising edge
	// ------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!we_n)
		begin
			mem[wr_addr] <= wr_data;
		end
		if (rd_en)
		begin
			rd_data <= mem[rd_addr];        // Holds between reads
		end
	end

	// Marks the cycle in which rd_data is fresh
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_en;
		end
	end

endmodule

// File: rtl/stack_pop_stage.sv
`timescale 1ns/1ps

module stack_pop_stage #(
	parameter type payload_t = logic [stack_pkg::DATA_W_DEF-1:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t rd_data,     // Word read from the RAM
	input  logic     rd_valid,    // rd_data is fresh
	output payload_t pop_data,
	output logic     pop_valid    // One-cycle pulse per popped word
);

	// ------------------------------------------------------------
	// Output data register
	// ------------------------------------------------------------

	// Only loads on a real read, so the last popped word stays put
	always_ff @(posedge clk)
	begin
		if (rd_valid)
		begin
			pop_data <= rd_data;
		end
	end

	// ------------------------------------------------------------
	// Valid pulse
	// ------------------------------------------------------------

	// Back-to-back reads give back-to-back pulses
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pop_valid <= 1'b0;
		end
		else
		begin
			pop_valid <= rd_valid;          // Second edge after the pop
		end
	end

endmodule

// File: rtl/stack_top.sv
`timescale 1ns/1ps

module stack_top #(
	parameter int                   DEPTH    = stack_pkg::STACK_DEPTH_DEF,
	parameter int                   DATA_W   = stack_pkg::DATA_W_DEF,
	parameter stack_pkg::err_mode_e ERR_MODE = stack_pkg::ERR_STICKY
) (
	input  logic              clk,
	input  logic              rst_n,        // Async, active low
	input  logic              push_req_n,
	input  logic              pop_req_n,
	input  logic [DATA_W-1:0] push_data,
	output logic              empty,
	output logic              full,
	output logic              error,
	output logic [DATA_W-1:0] pop_data,
	output logic              pop_valid
);

	// Same width rule as in the controller and the RAM
	localparam int ADDR_W = ($clog2(DEPTH) < 1) ? 1 : $clog2(DEPTH);

	typedef logic [DATA_W-1:0] word_t;      // Payload carried through RAM and pop stage

	logic              we_n;
	logic              rd_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	word_t             rd_data;
	logic              rd_valid;

	// ------------------------------------------------------------
	// Controller, input side
	// ------------------------------------------------------------

	stack_ctl #(
		.DEPTH    (DEPTH),
		.ERR_MODE (ERR_MODE)
	) u_ctl (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_req_n (push_req_n),
		.pop_req_n  (pop_req_n),
		.we_n       (we_n),
		.rd_en      (rd_en),
		.wr_addr    (wr_addr),
		.rd_addr    (rd_addr),
		.empty      (empty),
		.full       (full),
		.error      (error)
	);

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------

	stack_ram #(
		.DEPTH     (DEPTH),
		.payload_t (word_t)
	) u_ram (
		.clk      (clk),
		.rst_n    (rst_n),
		.we_n     (we_n),
		.wr_addr  (wr_addr),
		.wr_data  (push_data),              // Straight from the port
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	// Output register, two edges after the pop
	stack_pop_stage #(
		.payload_t (word_t)
	) u_pop (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.pop_data  (pop_data),
		.pop_valid (pop_valid)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 4                // Clock period in ns
) (
	output logic clk
);

	localparam int HALF = PERIOD / 2;

	// Free running clock that starts low
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#HALF clk = ~clk;
		end
	end

endmodule

// File: tests/stack_assert.sv
`timescale 1ns/1ps

module stack_assert (
	input logic clk,
	input logic rst_n,
	input logic we_n,             // RAM write enable, active low
	input logic rd_en,            // Pop accepted
	input logic empty,
	input logic full
);

	// ------------------------------------------------------------
	// Controller properties
	// ------------------------------------------------------------

	// Push priority keeps a write and a read apart
	a_wr_rd_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(!we_n && rd_en))
		else $error("write enable and read enable active in the same cycle");

	a_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(full && empty))         // Depth is at least one
		else $error("full and empty both high");

	// No write past the last slot
	a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
		full |-> we_n)
		else $error("write enabled while full");

endmodule

// Attached to every controller instance
bind stack_ctl stack_assert u_assert (
	.clk   (clk),
	.rst_n (rst_n),
	.we_n  (we_n),
	.rd_en (rd_en),
	.empty (empty),
	.full  (full)
);

// File: tests/tb_stack.sv
`timescale 1ns/1ps

module tb_stack #(
	parameter int ERR_MODE_SEL = 0          // 0 sticky, 1 per cycle
);

	import stack_pkg::*;

	localparam int        DEPTH        = STACK_DEPTH_DEF;
	localparam int        DATA_W       = DATA_W_DEF;
	localparam err_mode_e ERR_MODE     = (ERR_MODE_SEL == 0) ? ERR_STICKY : ERR_PER_CYCLE;
	localparam int        CLK_PERIOD   = 4;
	localparam int        DRIVE_DLY    = 1;      // Input skew after the rising edge
	localparam int        RESET_CYCLES = 5;
	localparam int        N_RANDOM     = 600;
	localparam int        BIAS_LEN     = 32;     // Cycles per random traffic mix
	// Directed fill, overflow, drain, underflow, priority and flush cycles
	localparam int        DIRECTED     = 2 * DEPTH + 22;
	localparam int        TOTAL_CYCLES = RESET_CYCLES + DIRECTED + N_RANDOM;
	localparam int        SEED         = 32'h237c245c;

	logic              clk;
	logic              rst_n;
	logic              push_req_n;
	logic              pop_req_n;
	logic [DATA_W-1:0] push_data;
	logic              empty;
	logic              full;
	logic              error;
	logic [DATA_W-1:0] pop_data;
	logic              pop_valid;

	// Reference model
	logic [DATA_W-1:0] model_q[$];          // Pushed words, top at the back
	int                model_cnt;
	logic              exp_error;
	logic              s1_valid;            // Pop accepted and word in the RAM register
	logic [DATA_W-1:0] s1_data;
	logic              s2_valid;            // Word expected on pop_data now
	logic [DATA_W-1:0] s2_data;
	logic              have_pop;            // At least one word popped so far
	logic [DATA_W-1:0] last_pop;            // Word pop_data must keep between pops
	int                n_pops;              // Words seen on pop_data

	tb_clock #(
		.PERIOD (CLK_PERIOD)
	) u_clk (
		.clk (clk)
	);

	stack_top #(
		.DEPTH    (DEPTH),
		.DATA_W   (DATA_W),
		.ERR_MODE (ERR_MODE)
	) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_req_n (push_req_n),
		.pop_req_n  (pop_req_n),
		.push_data  (push_data),
		.empty      (empty),
		.full       (full),
		.error      (error),
		.pop_data   (pop_data),
		.pop_valid  (pop_valid)
	);

	// ------------------------------------------------------------
	// Compare helpers
	// ------------------------------------------------------------

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			$display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
	                          input logic [DATA_W-1:0] exp);
		assert (got === exp)
		else
		begin
			$display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// All outputs against the model
	task automatic check_state();
		check_bit("empty", empty, model_cnt == 0);
		check_bit("full", full, model_cnt == DEPTH);
		check_bit("error", error, exp_error);
		check_bit("pop_valid", pop_valid, s2_valid);
		if (s2_valid)
		begin
			last_pop = s2_data;
			have_pop = 1'b1;
			n_pops++;
		end
		if (have_pop)
		begin
			check_word("pop_data", pop_data, last_pop);   // Fresh word or held word
		end
	endtask

	// ------------------------------------------------------------
	// One clock cycle of stimulus plus model update
	// ------------------------------------------------------------

	// Called at DRIVE_DLY after an edge, returns at the same point of the next cycle
	task automatic run_cycle(input logic push, input logic pop);
		logic [DATA_W-1:0] word;
		logic              push_acc;
		logic              pop_acc;
		logic              err_now;
		word       = DATA_W'($urandom());
		push_req_n = !push;
		pop_req_n  = !pop;
		push_data  = word;
		// Judged on the count before the edge with push first
		push_acc = push && (model_cnt < DEPTH);
		pop_acc  = pop && !push && (model_cnt > 0);
		err_now  = (push && model_cnt == DEPTH) || (pop && !push && model_cnt == 0);
		@(posedge clk);
		#DRIVE_DLY;
		s2_valid = s1_valid;                // Pop stage follows the RAM read
		s2_data  = s1_data;
		s1_valid = pop_acc;
		if (pop_acc)
		begin
			s1_data = model_q.pop_back();
			model_cnt--;
		end
		if (push_acc)
		begin
			model_q.push_back(word);
			model_cnt++;
		end
		if (ERR_MODE == ERR_STICKY)
		begin
			exp_error = exp_error || err_now;
		end
		else
		begin
			exp_error = err_now;
		end
		check_state();
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------

	initial
	begin
		int push_pct;
		int pop_pct;
		push_req_n = 1'b1;
		pop_req_n  = 1'b1;
		push_data  = '0;
		rst_n      = 1'b0;
		model_cnt  = 0;
		exp_error  = 1'b0;
		s1_valid   = 1'b0;
		s1_data    = '0;
		s2_valid   = 1'b0;
		s2_data    = '0;
		have_pop   = 1'b0;
		last_pop   = '0;
		n_pops     = 0;
		push_pct   = 50;
		pop_pct    = 50;
		void'($urandom(SEED));
		$display("stack test, depth %0d, error mode %s", DEPTH, ERR_MODE.name());

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		check_state();                      // Reset values

		// Fill up, then two pushes that must be dropped
		repeat (DEPTH + 2) run_cycle(1'b1, 1'b0);
		run_cycle(1'b0, 1'b1);              // Returns the last accepted word

		// Drain back to back, then pop while empty
		repeat (DEPTH + 2) run_cycle(1'b0, 1'b1);
		repeat (3) run_cycle(1'b0, 1'b0);   // Flush the pop pipeline

		// Both requests low should give a push only
		repeat (4) run_cycle(1'b1, 1'b1);
		repeat (4) run_cycle(1'b0, 1'b1);
		repeat (3) run_cycle(1'b0, 1'b0);

		// Random traffic with a new mix every BIAS_LEN cycles
		for (int i = 0; i < N_RANDOM; i++)
		begin
			if (i % BIAS_LEN == 0)
			begin
				push_pct = 15 + 20 * $urandom_range(3);
				pop_pct  = 15 + 20 * $urandom_range(3);
			end
			run_cycle($urandom_range(99) < push_pct, $urandom_range(99) < pop_pct);
		end
		repeat (3) run_cycle(1'b0, 1'b0);

		$display("popped %0d words, %0d left on the stack", n_pops, model_cnt);
		$display("TESTBENCH PASSED");
		$finish;
	end

	// Watchdog sized from the number of test cycles
	initial
	begin
		#((TOTAL_CYCLES + 100) * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in time");
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: list.f
rtl/stack_pkg.sv
rtl/stack_ctl.sv
rtl/stack_ram.sv
rtl/stack_pop_stage.sv
rtl/stack_top.sv
tests/tb_clock.sv
tests/stack_assert.sv
tests/tb_stack.sv

// File: Makefile
# Verilator build and run for the stack testbench
# Override on the command line, e.g. make simulate ERR_MODE=1

VERILATOR ?= verilator
TOP       ?= tb_stack
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
ERR_MODE  ?= 0
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: simulate clean

# Build, run, then look for the pass line in the log
simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		-GERR_MODE_SEL=$(ERR_MODE) --Mdir $(OBJ_DIR) -o V$(TOP)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
